// File: compile.f
priv_csr_pkg.sv
priv_trap_pkg.sv
priv_irq_sync.sv
priv_csr_rfile.sv
priv_trap_control.sv
priv_block.sv
tb_priv_block.sv

// File: run_sim.sh
#!/bin/sh
# Builds and runs the privilege unit testbench with Verilator.
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f compile.f --top-module tb_priv_block -o sim_priv
./obj_dir/sim_priv | tee sim.log
if grep -q "^TEST OK$" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

// File: tb_priv_block.sv
////////////////////////////////////////////////////////////
// Testbench for the machine-mode privilege unit.
// Random CSR, exception, mret and interrupt traffic, each
// cycle checked against a CSR reference model.
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_priv_block import priv_csr_pkg::*, priv_trap_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 10000;          // Tests need about 4300 cycles.
  localparam int OP_SWAP = 0;
  localparam int OP_SET  = 1;
  localparam int OP_CLR  = 2;

  logic      CLK = 1'b0;
  logic      rst_n;
  logic      fault_insn, mal_insn, illegal_insn, fault_l, mal_l, fault_s, mal_s;
  logic      breakpoint, env_m, ret, pipe_clear;
  logic      swap, set, clr, valid_write, instr;
  logic      insert_pc, intr, invalid_csr;
  logic      timer_int, soft_int, ext_int;
  logic      timer_int_clear, soft_int_clear, ext_int_clear;
  word_t     epc, badaddr, wdata, priv_pc, rdata;
  csr_addr_t addr;

  integer    seed = 32;
  int        errors = 0;
  int        checks = 0;
  int        cycle_count = 0;
  int        gap;
  word_t     c0, c1;                              // mcycle samples.
  csr_addr_t csr_list [11];                       // Every implemented CSR.

  // Reference model, all zero out of reset.
  logic      m_mstatus_mie = 1'b0, m_mstatus_mpie = 1'b0;
  irq_vec_t  m_mie = '0, m_pending = '0;
  irq_vec_t  m_set1 = '0, m_set2 = '0, m_clr1 = '0, m_clr2 = '0; // Sync delay line.
  word_t     m_mtvec = '0, m_mscratch = '0, m_mepc = '0, m_mcause = '0;
  word_t     m_mtval = '0, m_mcycle = '0, m_minstret = '0;

  priv_block dut0 (.*);

  always #20 CLK = ~CLK;                          // 40 ns period.

  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic compare_word(input string name, input word_t act, input word_t exp);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, act, exp);
    end
  endtask

  task automatic compare_flag(input string name, input logic act, input logic exp);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s is %b, expected %b", $time, name, act, exp);
    end
  endtask

  function automatic int rand_below(int n);
    return int'({$random(seed)} % n);
  endfunction

  // mip and mie layout, interrupt code is the bit index.
  function automatic word_t irq_word(irq_vec_t v);
    word_t w;
    w              = '0;
    w[IRQ_EXT_M]   = v[2];
    w[IRQ_SOFT_M]  = v[1];
    w[IRQ_TIMER_M] = v[0];
    return w;
  endfunction

  function automatic logic model_known(csr_addr_t a);
    foreach (csr_list[i]) begin
      if (csr_list[i] == a) return 1'b1;
    end
    return 1'b0;
  endfunction

  function automatic word_t model_read(csr_addr_t a);
    word_t w;
    w = '0;                                       // mhartid and unknown read zero.
    case (a)
      CSR_MSTATUS: begin
        w[MSTATUS_MIE]  = m_mstatus_mie;
        w[MSTATUS_MPIE] = m_mstatus_mpie;
      end
      CSR_MIE:      w = irq_word(m_mie);
      CSR_MIP:      w = irq_word(m_pending);
      CSR_MTVEC:    w = m_mtvec;
      CSR_MSCRATCH: w = m_mscratch;
      CSR_MEPC:     w = m_mepc;
      CSR_MCAUSE:   w = m_mcause;
      CSR_MTVAL:    w = m_mtval;
      CSR_MCYCLE:   w = m_mcycle;
      CSR_MINSTRET: w = m_minstret;
      default:      w = '0;
    endcase
    return w;
  endfunction

  // Exception order: breakpoint first, load fault last.
  function automatic exc_code_t model_exc_code();
    if (breakpoint) return EXC_BREAKPOINT;
    if (fault_insn) return EXC_INSN_FAULT;
    if (illegal_insn) return EXC_ILLEGAL;
    if (mal_insn) return EXC_INSN_MISALIGNED;
    if (env_m) return EXC_ECALL_M;
    if (mal_s) return EXC_STORE_MISALIGNED;
    if (mal_l) return EXC_LOAD_MISALIGNED;
    if (fault_s) return EXC_STORE_FAULT;
    return EXC_LOAD_FAULT;
  endfunction

  function automatic exc_code_t model_irq_code(irq_vec_t p);
    if (p[2]) return IRQ_EXT_M;
    if (p[1]) return IRQ_SOFT_M;
    return IRQ_TIMER_M;
  endfunction

  // All inputs idle, with random trap data and retire pulse.
  task automatic idle_inputs();
    {fault_insn, mal_insn, illegal_insn, fault_l, mal_l, fault_s, mal_s} <= '0;
    {breakpoint, env_m, ret, pipe_clear, swap, set, clr, valid_write} <= '0;
    {timer_int, soft_int, ext_int, timer_int_clear, soft_int_clear, ext_int_clear} <= '0;
    wdata   <= '0;
    epc     <= word_t'($random(seed));
    badaddr <= word_t'($random(seed));
    instr   <= 1'($random(seed));
  endtask

  // Checks outputs mid-cycle, then steps the model past the next edge.
  task automatic check_cycle();
    logic      exc_any, irq_take, trap, mret, access, known, bad, we;
    irq_vec_t  en_pend;
    exc_code_t code;
    word_t     old_val, new_val;
    @(negedge CLK);
    exc_any  = breakpoint | fault_insn | illegal_insn | mal_insn | env_m |
               mal_s | mal_l | fault_s | fault_l;
    en_pend  = m_mie & m_pending;
    irq_take = !exc_any && pipe_clear && m_mstatus_mie && (en_pend != '0);
    trap     = exc_any || irq_take;
    mret     = ret && !trap;
    access   = swap | set | clr;
    known    = model_known(addr);
    old_val  = model_read(addr);
    bad      = access && (!known || (valid_write && addr == CSR_MHARTID));
    compare_flag("insert_pc", insert_pc, trap | mret);
    compare_flag("intr", intr, irq_take);
    compare_flag("invalid_csr", invalid_csr, bad);
    if (trap) begin
      compare_word("priv_pc", priv_pc, m_mtvec);
    end else if (mret) begin
      compare_word("priv_pc", priv_pc, m_mepc);
    end
    if (known) compare_word("rdata", rdata, old_val);
    code    = exc_any ? model_exc_code() : model_irq_code(en_pend);
    new_val = swap ? wdata : (set ? (old_val | wdata) : (old_val & ~wdata));
    we      = access && valid_write && !bad && !trap;
    if (trap) begin
      m_mepc         = epc;
      m_mcause       = {irq_take, 27'd0, code};
      m_mtval        = irq_take ? '0 : badaddr;   // No address for interrupts.
      m_mstatus_mpie = m_mstatus_mie;
      m_mstatus_mie  = 1'b0;
    end else if (mret) begin
      m_mstatus_mie  = m_mstatus_mpie;
      m_mstatus_mpie = 1'b1;
    end else if (we && addr == CSR_MSTATUS) begin
      m_mstatus_mie  = new_val[MSTATUS_MIE];
      m_mstatus_mpie = new_val[MSTATUS_MPIE];
    end
    if (we) begin
      case (addr)
        CSR_MIE:      m_mie = {new_val[IRQ_EXT_M], new_val[IRQ_SOFT_M], new_val[IRQ_TIMER_M]};
        CSR_MTVEC:    m_mtvec = {new_val[31:2], 2'b00};   // Mode bits read zero.
        CSR_MSCRATCH: m_mscratch = new_val;
        CSR_MEPC:     m_mepc = new_val;
        CSR_MCAUSE:   m_mcause = new_val;
        CSR_MTVAL:    m_mtval = new_val;
        default:      ;
      endcase
    end
    if (we && addr == CSR_MCYCLE) m_mcycle = new_val;
    else m_mcycle = m_mcycle + 32'd1;
    if (we && addr == CSR_MINSTRET) m_minstret = new_val;
    else if (instr) m_minstret = m_minstret + 32'd1;
    m_pending = (m_pending | m_set2) & ~m_clr2;   // Clear wins.
    m_set2    = m_set1;
    m_clr2    = m_clr1;
    m_set1    = {ext_int, soft_int, timer_int};
    m_clr1    = {ext_int_clear, soft_int_clear, timer_int_clear};
  endtask

  task automatic csr_write(input csr_addr_t a, input word_t d, input int kind, input logic vw);
    @(posedge CLK);
    idle_inputs();
    addr        <= a;
    wdata       <= d;
    swap        <= (kind == OP_SWAP);
    set         <= (kind == OP_SET);
    clr         <= (kind == OP_CLR);
    valid_write <= vw;
    check_cycle();
  endtask

  task automatic csr_read(input csr_addr_t a);
    @(posedge CLK);
    idle_inputs();
    addr <= a;
    set  <= 1'b1;                                 // Set with zero operand, no write.
    check_cycle();
  endtask

  task automatic raise_exception(input int pick);
    @(posedge CLK);
    idle_inputs();
    case (pick)
      0:       breakpoint   <= 1'b1;
      1:       fault_insn   <= 1'b1;
      2:       illegal_insn <= 1'b1;
      3:       mal_insn     <= 1'b1;
      4:       env_m        <= 1'b1;
      5:       mal_s        <= 1'b1;
      6:       mal_l        <= 1'b1;
      7:       fault_s      <= 1'b1;
      default: fault_l      <= 1'b1;
    endcase
    check_cycle();
  endtask

  initial begin
    csr_list = '{CSR_MSTATUS, CSR_MIE, CSR_MTVEC, CSR_MSCRATCH, CSR_MEPC, CSR_MCAUSE,
                 CSR_MTVAL, CSR_MIP, CSR_MCYCLE, CSR_MINSTRET, CSR_MHARTID};
    rst_n <= 1'b0;
    addr  <= CSR_MSTATUS;
    idle_inputs();
    repeat (7) @(posedge CLK);
    @(posedge CLK);
    idle_inputs();
    rst_n <= 1'b1;                                // Released on the 8th edge.
    check_cycle();
    foreach (csr_list[i]) begin                   // Counters already run.
      csr_read(csr_list[i]);
      if (csr_list[i] != CSR_MCYCLE && csr_list[i] != CSR_MINSTRET)
        compare_word("reset rdata", rdata, '0);
    end
    for (int i = 0; i < 600; i++) begin           // CSR access, some to bad addresses.
      csr_addr_t a;
      if (rand_below(4) == 0) a = csr_addr_t'($random(seed));
      else a = csr_list[rand_below(11)];
      csr_write(a, word_t'($random(seed)), rand_below(3), rand_below(8) != 0);
      csr_read(a);
    end
    for (int i = 0; i < 300; i++) begin           // Exception then mret.
      if (rand_below(2) == 0) csr_write(CSR_MSTATUS, word_t'($random(seed)), OP_SWAP, 1'b1);
      if (rand_below(8) == 0) csr_write(CSR_MTVEC, word_t'($random(seed)), OP_SWAP, 1'b1);
      raise_exception(rand_below(9));
      csr_read(CSR_MEPC);
      csr_read(CSR_MCAUSE);
      csr_read(CSR_MTVAL);
      csr_read(CSR_MSTATUS);
      @(posedge CLK);
      idle_inputs();
      ret <= 1'b1;
      check_cycle();
      csr_read(CSR_MSTATUS);
    end
    for (int i = 0; i < 80; i++) begin            // Interrupt pulses with random enables.
      csr_write(CSR_MIE, word_t'($random(seed)), OP_SWAP, 1'b1);
      csr_write(CSR_MSTATUS, word_t'($random(seed)), OP_SWAP, 1'b1);
      repeat (6) begin
        @(posedge CLK);
        idle_inputs();
        addr            <= CSR_MIP;
        set             <= 1'b1;
        pipe_clear      <= 1'b1;
        timer_int       <= (rand_below(4) == 0);
        soft_int        <= (rand_below(4) == 0);
        ext_int         <= (rand_below(4) == 0);
        timer_int_clear <= (rand_below(4) == 0);
        soft_int_clear  <= (rand_below(4) == 0);
        ext_int_clear   <= (rand_below(4) == 0);
        check_cycle();
      end
      csr_read(CSR_MCAUSE);
    end
    for (int i = 0; i < 10; i++) begin            // Counter deltas.
      csr_read(CSR_MCYCLE);
      c0  = rdata;
      gap = rand_below(5);
      repeat (gap) csr_read(CSR_MINSTRET);
      csr_read(CSR_MCYCLE);
      c1 = rdata;
      compare_word("mcycle delta", c1 - c0, word_t'(gap + 1));
      csr_write(CSR_MINSTRET, word_t'($random(seed)), OP_SWAP, 1'b1);
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: priv_block.sv
////////////////////////////////////////////////////////////
// Machine-mode privilege unit top level.
// Joins the interrupt synchronizer, the CSR file and the
// trap control between the pipeline and interrupt ports.
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module priv_block import priv_csr_pkg::*, priv_trap_pkg::*; (
  input  logic      CLK,
  input  logic      rst_n,
  // Exception strobes from the pipeline.
  input  logic      fault_insn,
  input  logic      mal_insn,
  input  logic      illegal_insn,
  input  logic      fault_l,
  input  logic      mal_l,
  input  logic      fault_s,
  input  logic      mal_s,
  input  logic      breakpoint,
  input  logic      env_m,
  input  word_t     epc,                          // Trapping PC.
  input  word_t     badaddr,                      // Fault address.
  input  logic      ret,                          // mret.
  input  logic      pipe_clear,
  // CSR access.
  input  csr_addr_t addr,
  input  word_t     wdata,
  input  logic      swap,
  input  logic      set,
  input  logic      clr,
  input  logic      valid_write,
  input  logic      instr,                        // Retire pulse.
  output word_t     priv_pc,
  output logic      insert_pc,
  output logic      intr,
  output word_t     rdata,
  output logic      invalid_csr,
  // Interrupt sources.
  input  logic      timer_int,
  input  logic      soft_int,
  input  logic      ext_int,
  input  logic      timer_int_clear,
  input  logic      soft_int_clear,
  input  logic      ext_int_clear
);

  irq_vec_t  pending;                             // Synchronizer to CSR file.
  logic      mstatus_mie;                         // CSR file to trap control.
  irq_vec_t  mie_bits;
  word_t     mtvec_base;
  word_t     mepc_q;
  logic      trap_take;                           // Trap control to CSR file.
  logic      trap_is_irq;
  exc_code_t trap_code;
  logic      mret_take;

  priv_irq_sync     irq_sync_i  (.*);
  priv_csr_rfile    csr_rfile_i (.*);
  priv_trap_control trap_ctrl_i (.*);

endmodule

// File: priv_trap_control.sv
////////////////////////////////////////////////////////////
// Trap control.
// Picks the cause of a trap, decides whether a trap or an
// mret redirects the pipeline and drives the new PC.
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module priv_trap_control import priv_csr_pkg::*, priv_trap_pkg::*; (
  input  logic      fault_insn,                   // Instruction access fault.
  input  logic      mal_insn,                     // Misaligned fetch target.
  input  logic      illegal_insn,
  input  logic      fault_l,                      // Load access fault.
  input  logic      mal_l,                        // Misaligned load.
  input  logic      fault_s,                      // Store access fault.
  input  logic      mal_s,                        // Misaligned store.
  input  logic      breakpoint,                   // ebreak.
  input  logic      env_m,                        // ecall from machine mode.
  input  logic      ret,                          // mret in the pipeline.
  input  logic      pipe_clear,                   // Safe point for an interrupt.
  input  logic      mstatus_mie,
  input  irq_vec_t  mie_bits,                     // Enabled and pending interrupts.
  input  word_t     mtvec_base,
  input  word_t     mepc_q,
  output word_t     priv_pc,                      // Redirect target.
  output logic      insert_pc,                    // Redirect this cycle.
  output logic      intr,                         // Redirect is an interrupt.
  output logic      trap_take,
  output logic      trap_is_irq,
  output exc_code_t trap_code,
  output logic      mret_take
);

  logic      exc_present;                         // Any exception strobe high.
  logic      irq_take;
  exc_code_t exc_code;                            // Highest priority exception.
  exc_code_t irq_code;                            // Highest priority interrupt.

  assign exc_present = breakpoint | fault_insn | illegal_insn | mal_insn | env_m |
                       mal_s | mal_l | fault_s | fault_l;

  // Exception priority.
  always_comb begin
    if (breakpoint) begin
      exc_code = EXC_BREAKPOINT;
    end else if (fault_insn) begin
      exc_code = EXC_INSN_FAULT;
    end else if (illegal_insn) begin
      exc_code = EXC_ILLEGAL;
    end else if (mal_insn) begin
      exc_code = EXC_INSN_MISALIGNED;
    end else if (env_m) begin
      exc_code = EXC_ECALL_M;
    end else if (mal_s) begin
      exc_code = EXC_STORE_MISALIGNED;
    end else if (mal_l) begin
      exc_code = EXC_LOAD_MISALIGNED;
    end else if (fault_s) begin
      exc_code = EXC_STORE_FAULT;
    end else begin
      exc_code = EXC_LOAD_FAULT;                  // Also the idle value.
    end
  end

  // Interrupt priority. External, then software, then timer.
  always_comb begin
    if (mie_bits[IRQ_IDX_EXT]) begin
      irq_code = IRQ_EXT_M;
    end else if (mie_bits[IRQ_IDX_SOFT]) begin
      irq_code = IRQ_SOFT_M;
    end else begin
      irq_code = IRQ_TIMER_M;
    end
  end

  // Interrupts wait for a clean pipeline and yield to exceptions.
  assign irq_take    = ~exc_present & pipe_clear & mstatus_mie & (|mie_bits);
  assign trap_take   = exc_present | irq_take;
  assign trap_is_irq = irq_take;
  assign trap_code   = exc_present ? exc_code : irq_code;
  assign mret_take   = ret & ~trap_take;          // A trap wins over mret.

  // Redirect to the pipeline.
  assign insert_pc = trap_take | mret_take;
  assign intr      = irq_take;
  assign priv_pc   = trap_take ? mtvec_base : mepc_q; // Direct mode vector.

endmodule

// File: priv_csr_rfile.sv
////////////////////////////////////////////////////////////
// Machine CSR register file.
// Decodes CSR accesses, stores the machine CSRs, applies
// trap and mret updates and runs mcycle and minstret.
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module priv_csr_rfile import priv_csr_pkg::*, priv_trap_pkg::*; (
  input  logic      CLK,
  input  logic      rst_n,
  input  csr_addr_t addr,                         // CSR address of the access.
  input  word_t     wdata,                        // Operand for swap, set or clear.
  input  logic      swap,                         // csrrw style access.
  input  logic      set,                          // csrrs style access.
  input  logic      clr,                          // csrrc style access.
  input  logic      valid_write,                  // Access really writes the CSR.
  input  logic      instr,                        // Instruction retired this cycle.
  input  irq_vec_t  pending,                      // Synchronized pending bits.
  input  logic      trap_take,                    // Trap entered this cycle.
  input  logic      trap_is_irq,
  input  exc_code_t trap_code,
  input  logic      mret_take,                    // mret executed this cycle.
  input  word_t     epc,                          // PC of the trapping instruction.
  input  word_t     badaddr,                      // Fault address for mtval.
  output word_t     rdata,                        // Old CSR value.
  output logic      invalid_csr,
  output logic      mstatus_mie,
  output irq_vec_t  mie_bits,                     // Pending interrupts masked by mie.
  output word_t     mtvec_base,
  output word_t     mepc_q
);

  logic     mstatus_mie_q, mstatus_mpie_q;        // The two stored mstatus bits.
  irq_vec_t mie_q;                                // Enables in pending vector order.
  word_t    mtvec_q;                              // Mode bits always zero.
  word_t    mscratch_q, mcause_q, mtval_q;
  word_t    mcycle_q, minstret_q;
  word_t    csr_old, csr_new;
  logic     addr_known;                           // Address maps to an implemented CSR.
  logic     csr_access;
  logic     csr_we;                               // Write commits at the clock edge.

  // Spread a pending vector over the mip and mie bit layout.
  function automatic word_t irq_to_word(irq_vec_t v);
    word_t w;
    w              = '0;
    w[IRQ_EXT_M]   = v[IRQ_IDX_EXT];
    w[IRQ_SOFT_M]  = v[IRQ_IDX_SOFT];
    w[IRQ_TIMER_M] = v[IRQ_IDX_TIMER];
    return w;
  endfunction

  // Read decode.
  always_comb begin
    csr_old    = '0;
    addr_known = 1'b1;
    case (addr)
      CSR_MSTATUS: begin
        csr_old[MSTATUS_MIE]  = mstatus_mie_q;
        csr_old[MSTATUS_MPIE] = mstatus_mpie_q;
      end
      CSR_MIE:      csr_old = irq_to_word(mie_q);
      CSR_MIP:      csr_old = irq_to_word(pending); // Live pending bits.
      CSR_MTVEC:    csr_old = mtvec_q;
      CSR_MSCRATCH: csr_old = mscratch_q;
      CSR_MEPC:     csr_old = mepc_q;
      CSR_MCAUSE:   csr_old = mcause_q;
      CSR_MTVAL:    csr_old = mtval_q;
      CSR_MCYCLE:   csr_old = mcycle_q;
      CSR_MINSTRET: csr_old = minstret_q;
      CSR_MHARTID:  csr_old = MHARTID_VALUE;
      default:      addr_known = 1'b0;           // Unimplemented address.
    endcase
  end

  assign rdata       = csr_old;
  assign csr_access  = swap | set | clr;
  assign invalid_csr = csr_access &
                       (~addr_known | (valid_write & (addr == CSR_MHARTID)));
  assign csr_we      = csr_access & valid_write & ~invalid_csr & ~trap_take;

  // Write value from the old value and the operand.
  always_comb begin
    if (swap) begin
      csr_new = wdata;
    end else if (set) begin
      csr_new = csr_old | wdata;
    end else begin
      csr_new = csr_old & ~wdata;
    end
  end

  // mstatus. Trap entry first, then mret, then software.
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      mstatus_mie_q  <= 1'b0;
      mstatus_mpie_q <= 1'b0;
    end else if (trap_take) begin
      mstatus_mpie_q <= mstatus_mie_q;            // Save the enable.
      mstatus_mie_q  <= 1'b0;                     // Handler runs masked.
    end else if (mret_take) begin
      mstatus_mie_q  <= mstatus_mpie_q;
      mstatus_mpie_q <= 1'b1;
    end else if (csr_we && addr == CSR_MSTATUS) begin
      mstatus_mie_q  <= csr_new[MSTATUS_MIE];
      mstatus_mpie_q <= csr_new[MSTATUS_MPIE];
    end
  end

  // Software-only CSRs.
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      mie_q      <= '0;
      mtvec_q    <= MTVEC_RESET;
      mscratch_q <= MSCRATCH_RESET;
    end else if (csr_we) begin
      if (addr == CSR_MIE) begin
        mie_q[IRQ_IDX_EXT]   <= csr_new[IRQ_EXT_M];
        mie_q[IRQ_IDX_SOFT]  <= csr_new[IRQ_SOFT_M];
        mie_q[IRQ_IDX_TIMER] <= csr_new[IRQ_TIMER_M];
      end
      if (addr == CSR_MTVEC) mtvec_q <= csr_new & MTVEC_BASE_MASK;
      if (addr == CSR_MSCRATCH) mscratch_q <= csr_new;
    end
  end

  // Trap CSRs, loaded by hardware on trap entry.
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      mepc_q   <= MEPC_RESET;
      mcause_q <= MCAUSE_RESET;
      mtval_q  <= MTVAL_RESET;
    end else if (trap_take) begin
      mepc_q                   <= epc;
      mcause_q                 <= '0;
      mcause_q[MCAUSE_INT_BIT] <= trap_is_irq;
      mcause_q[EXC_CODE_W-1:0] <= trap_code;
      mtval_q                  <= trap_is_irq ? '0 : badaddr; // No address for interrupts.
    end else if (csr_we) begin
      if (addr == CSR_MEPC) mepc_q <= csr_new;
      if (addr == CSR_MCAUSE) mcause_q <= csr_new;
      if (addr == CSR_MTVAL) mtval_q <= csr_new;
    end
  end

  // Counters. A software write replaces the increment.
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      mcycle_q   <= COUNTER_RESET;
      minstret_q <= COUNTER_RESET;
    end else begin
      if (csr_we && addr == CSR_MCYCLE) begin
        mcycle_q <= csr_new;
      end else begin
        mcycle_q <= mcycle_q + 32'd1;             // Every cycle.
      end
      if (csr_we && addr == CSR_MINSTRET) begin
        minstret_q <= csr_new;
      end else if (instr) begin
        minstret_q <= minstret_q + 32'd1;         // Retire pulses only.
      end
    end
  end

  // Values used by the trap control.
  assign mstatus_mie = mstatus_mie_q;
  assign mie_bits    = mie_q & pending;
  assign mtvec_base  = mtvec_q;

endmodule

// File: priv_irq_sync.sv
////////////////////////////////////////////////////////////
// Interrupt line synchronizer.
// Brings the timer, software and external set and clear
// lines into the core clock and holds the pending bits.
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module priv_irq_sync import priv_trap_pkg::*; (
  input  logic     CLK,
  input  logic     rst_n,
  input  logic     timer_int,                     // Set pulses from the interrupt sources.
  input  logic     soft_int,
  input  logic     ext_int,
  input  logic     timer_int_clear,               // Clear pulses, same sources.
  input  logic     soft_int_clear,
  input  logic     ext_int_clear,
  output irq_vec_t pending                        // Latched pending bits.
);

  irq_vec_t set_raw, clr_raw;                     // Lines gathered into vectors.
  irq_vec_t set_s1, set_s2;                       // Set synchronizer stages.
  irq_vec_t clr_s1, clr_s2;                       // Clear synchronizer stages.
  irq_vec_t pending_q;

  always_comb begin
    set_raw                = '0;
    clr_raw                = '0;
    set_raw[IRQ_IDX_EXT]   = ext_int;
    set_raw[IRQ_IDX_SOFT]  = soft_int;
    set_raw[IRQ_IDX_TIMER] = timer_int;
    clr_raw[IRQ_IDX_EXT]   = ext_int_clear;
    clr_raw[IRQ_IDX_SOFT]  = soft_int_clear;
    clr_raw[IRQ_IDX_TIMER] = timer_int_clear;
  end

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      set_s1    <= '0;
      set_s2    <= '0;
      clr_s1    <= '0;
      clr_s2    <= '0;
      pending_q <= '0;
    end else begin
      set_s1    <= set_raw;                       // First stage, may go metastable.
      set_s2    <= set_s1;                        // Second stage, stable.
      clr_s1    <= clr_raw;
      clr_s2    <= clr_s1;
      pending_q <= (pending_q | set_s2) & ~clr_s2; // Clear wins over set.
    end
  end

  assign pending = pending_q;

endmodule

// File: priv_trap_pkg.sv
////////////////////////////////////////////////////////////
// Trap definitions for the privilege unit.
// Exception and interrupt cause codes and the layout of
// the internal pending interrupt vector.
////////////////////////////////////////////////////////////

package priv_trap_pkg;

  localparam int EXC_CODE_W = 4;                  // Cause codes fit in four bits.
  typedef logic [EXC_CODE_W-1:0] exc_code_t;      // mcause exception code field.

  // Synchronous exception codes.
  localparam exc_code_t EXC_INSN_MISALIGNED  = 4'd0;
  localparam exc_code_t EXC_INSN_FAULT       = 4'd1;
  localparam exc_code_t EXC_ILLEGAL          = 4'd2;
  localparam exc_code_t EXC_BREAKPOINT       = 4'd3;
  localparam exc_code_t EXC_LOAD_MISALIGNED  = 4'd4;
  localparam exc_code_t EXC_LOAD_FAULT       = 4'd5;
  localparam exc_code_t EXC_STORE_MISALIGNED = 4'd6;
  localparam exc_code_t EXC_STORE_FAULT      = 4'd7;
  localparam exc_code_t EXC_ECALL_M          = 4'd11;

  // Machine interrupt codes, also the bit positions in mip and mie.
  localparam exc_code_t IRQ_SOFT_M  = 4'd3;
  localparam exc_code_t IRQ_TIMER_M = 4'd7;
  localparam exc_code_t IRQ_EXT_M   = 4'd11;

  localparam int MCAUSE_INT_BIT = 31;             // Set in mcause for interrupts.

  // Pending vector, highest priority in the top bit.
  localparam int IRQ_NUM = 3;
  typedef logic [IRQ_NUM-1:0] irq_vec_t;          // {external, software, timer}.

  localparam int IRQ_IDX_EXT   = 2;               // Taken first.
  localparam int IRQ_IDX_SOFT  = 1;
  localparam int IRQ_IDX_TIMER = 0;               // Taken last.

endpackage

// File: priv_csr_pkg.sv
////////////////////////////////////////////////////////////
// Machine CSR definitions for the privilege unit.
// Holds data widths, the CSR address map, mstatus bit
// positions and the reset values of the CSR storage.
////////////////////////////////////////////////////////////

package priv_csr_pkg;

  // Basic widths.
  localparam int XLEN       = 32;                 // Data path width.
  localparam int CSR_ADDR_W = 12;                 // Width of a CSR address.

  typedef logic [XLEN-1:0]       word_t;          // CSR data, PCs and fault addresses.
  typedef logic [CSR_ADDR_W-1:0] csr_addr_t;      // CSR address from the instruction.

  // Machine information and trap setup.
  localparam csr_addr_t CSR_MSTATUS  = 12'h300;   // Machine status.
  localparam csr_addr_t CSR_MIE      = 12'h304;   // Interrupt enables.
  localparam csr_addr_t CSR_MTVEC    = 12'h305;   // Trap vector base.

  // Machine trap handling.
  localparam csr_addr_t CSR_MSCRATCH = 12'h340;   // Handler scratch word.
  localparam csr_addr_t CSR_MEPC     = 12'h341;   // Exception PC.
  localparam csr_addr_t CSR_MCAUSE   = 12'h342;   // Trap cause.
  localparam csr_addr_t CSR_MTVAL    = 12'h343;   // Faulting address.
  localparam csr_addr_t CSR_MIP      = 12'h344;   // Interrupt pending, read only here.

  // Counters, lower halves only.
  localparam csr_addr_t CSR_MCYCLE   = 12'hB00;   // Cycle counter.
  localparam csr_addr_t CSR_MINSTRET = 12'hB02;   // Retired instruction counter.

  // Read-only machine information.
  localparam csr_addr_t CSR_MHARTID  = 12'hF14;   // Hart number.

  // mstatus fields that are implemented.
  localparam int MSTATUS_MIE  = 3;                // Global machine interrupt enable.
  localparam int MSTATUS_MPIE = 7;                // MIE saved on trap entry.

  // Direct mode only, so the two mode bits are never stored.
  localparam word_t MTVEC_BASE_MASK = 32'hFFFF_FFFC;

  // Reset values of the CSR storage.
  localparam word_t MTVEC_RESET    = 32'h0000_0000; // Handler at address zero.
  localparam word_t MEPC_RESET     = 32'h0000_0000;
  localparam word_t MCAUSE_RESET   = 32'h0000_0000;
  localparam word_t MTVAL_RESET    = 32'h0000_0000;
  localparam word_t MSCRATCH_RESET = 32'h0000_0000;
  localparam word_t COUNTER_RESET  = 32'h0000_0000; // mcycle and minstret.

  // Single hart design.
  localparam word_t MHARTID_VALUE  = 32'h0000_0000;

endpackage
